/* common/norm_check_pkg.sv */
/*
  Shared widths, constants and types of the ML-DSA infinity-norm check.
  Bounds follow the ML-DSA-65 parameter set (gamma1 = 2^19, beta = 196).
  Coefficients are residues modulo q held in the low 23 bits of a 24-bit lane.
*/
package norm_check_pkg;

    // Datapath widths
    localparam int coeff_w = 24;
    localparam int q_w = 23;
    localparam int lanes = 4;
    localparam int word_w = coeff_w * lanes;
    localparam int addr_w = 8;
    localparam int rand_w = 6;

    // One polynomial of 256 coefficients spans 64 memory words
    localparam int words_per_poly = 64;
    localparam int mem_depth = 1 << addr_w;

    typedef logic [coeff_w-1:0] coeff_t;
    typedef logic [word_w-1:0] mem_word_t;
    typedef logic [addr_w-1:0] mem_addr_t;
    typedef logic [1:0] chk_mode_t;
    typedef logic [rand_w-1:0] rand_t;

    // The ML-DSA modulus and the split point of the centered representation
    localparam logic [q_w-1:0] mldsa_q = 23'd8380417;
    localparam coeff_t mldsa_q_half = coeff_t'((mldsa_q - 1) / 2);

    // Scheme parameters that the three norm bounds are built from
    localparam int gamma1 = 1 << 19;
    localparam int gamma2 = (mldsa_q - 1) / 32;
    localparam int beta = 196;

    // A coefficient fails its check when the centered magnitude reaches the bound
    localparam coeff_t bound_z = coeff_t'(gamma1 - beta);
    localparam coeff_t bound_r0 = coeff_t'(gamma2 - beta);
    localparam coeff_t bound_ct0 = coeff_t'(gamma2);

    // Mode codes, where the unused code 3 falls back to the ct0 bound
    localparam chk_mode_t mode_z = 2'd0;
    localparam chk_mode_t mode_r0 = 2'd1;
    localparam chk_mode_t mode_ct0 = 2'd2;

endpackage

/* common/coeff_rd_if.sv */
/*
  Read path of the coefficient memory. Data returns exactly one cycle
  after the request with rd_data_valid high, and the path never stalls.
*/
`timescale 1ns/1ns

interface coeff_rd_if;
    import norm_check_pkg::*;

    // Request side, driven by the read controller
    logic rd_en;
    mem_addr_t rd_addr;

    // Response side, driven by the memory
    logic rd_data_valid;
    mem_word_t rd_data;

    modport requester (
        output rd_en,
        output rd_addr
    );

    modport responder (
        input rd_en,
        input rd_addr,
        output rd_data_valid,
        output rd_data
    );

    // The check datapath only watches the returning words
    modport consumer (
        input rd_data_valid,
        input rd_data
    );

endinterface

/* logic/coeff_mem.sv */
/*
  Single-port-write, single-port-read coefficient memory of 256 words.
  Reset leaves the contents as they are. A write and a read to the same
  word in one cycle return an unspecified word.
*/
`timescale 1ns/1ns

module coeff_mem (
    input logic clk,
    input logic reset_n,
    input logic wr_en,
    input norm_check_pkg::mem_addr_t wr_addr,
    input norm_check_pkg::mem_word_t wr_data,
    coeff_rd_if.responder rd
);
    import norm_check_pkg::*;

    mem_word_t mem [mem_depth];
    mem_word_t rd_data_q;
    logic rd_valid_q;

    // Writes land at the clock edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // The addressed word is captured at the edge that samples rd_en
    always_ff @(posedge clk) begin
        if (rd.rd_en) begin
            rd_data_q <= mem[rd.rd_addr];
        end
    end

    // The valid flag marks the cycle after each accepted request
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd.rd_en;
        end
    end

    assign rd.rd_data = rd_data_q;
    assign rd.rd_data_valid = rd_valid_q;

endmodule

/* norm_check/norm_check_unit.sv */
/*
  Centered-magnitude bound check of one coefficient lane.
  Only the low 23 bits of the lane are used. Values at or above q get no
  second reduction and go through the same formula.
*/
`timescale 1ns/1ns

module norm_check_unit (
    input logic enable,
    input norm_check_pkg::chk_mode_t mode,
    input norm_check_pkg::coeff_t coeff,
    output logic invalid
);
    import norm_check_pkg::*;

    coeff_t val;
    coeff_t mag;
    coeff_t bound;

    // The top bit of the lane is padding and is dropped here
    assign val = coeff_t'(coeff[q_w-1:0]);

    // Upper half residues stand for negative values, so q - x is their size
    always_comb begin
        if (val > mldsa_q_half) begin
            mag = coeff_t'(mldsa_q) - val;
        end else begin
            mag = val;
        end
    end

    // Bound selection per mode, with the spare code acting as ct0
    always_comb begin
        case (mode)
            mode_z: bound = bound_z;
            mode_r0: bound = bound_r0;
            mode_ct0: bound = bound_ct0;
            default: bound = bound_ct0;
        endcase
    end

    // A lane is flagged only while its word is valid on the read bus
    assign invalid = enable && (mag >= bound);

endmodule

/* norm_check/norm_check_ctrl.sv */
/*
  Issues the 64 reads of one polynomial in an order rotated by the
  randomness input. Enables that arrive while busy are dropped, and
  zeroize aborts a run without a last_beat.
*/
`timescale 1ns/1ns

module norm_check_ctrl (
    input logic clk,
    input logic reset_n,
    input logic zeroize,
    input logic enable,
    input norm_check_pkg::rand_t randomness,
    input norm_check_pkg::mem_addr_t base_addr,
    coeff_rd_if.requester rd,
    output logic last_beat
);
    import norm_check_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_reading,
        st_drain
    } state_t;

    state_t state;
    rand_t step;
    rand_t next_off;
    rand_t rand_q;
    mem_addr_t base_q;
    mem_addr_t rd_addr_q;
    logic rd_en_q;
    logic start;
    logic last_step;

    // A run starts only from idle, so an enable during a run is ignored
    assign start = (state == st_idle) && enable;
    assign last_step = (step == rand_t'(words_per_poly - 1));

    // Offset of the next read, wrapping inside the 64-word polynomial
    assign next_off = step + rand_t'(1) + rand_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_idle;
            step <= '0;
            rd_en_q <= 1'b0;
        end else if (zeroize) begin
            state <= st_idle;
            step <= '0;
            rd_en_q <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (enable) begin
                        state <= st_reading;
                        step <= '0;
                        rd_en_q <= 1'b1;
                    end
                end
                st_reading: begin
                    // The 64th request is on the bus during this cycle
                    if (last_step) begin
                        state <= st_drain;
                        rd_en_q <= 1'b0;
                    end else begin
                        step <= step + rand_t'(1);
                    end
                end
                // One cycle for the final word to come back from memory
                st_drain: state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // Base and rotation are latched at the start so they may change later
    always_ff @(posedge clk) begin
        if (start) begin
            base_q <= base_addr;
            rand_q <= randomness;
            rd_addr_q <= base_addr + mem_addr_t'(randomness);
        end else if (state == st_reading) begin
            // Addresses wrap modulo 256 above the base
            rd_addr_q <= base_q + mem_addr_t'(next_off);
        end
    end

    assign rd.rd_en = rd_en_q;
    assign rd.rd_addr = rd_addr_q;

    // The final data word is valid exactly while the FSM drains
    assign last_beat = (state == st_drain);

endmodule

/* norm_check/norm_check_top.sv */
/*
  Checks four lanes per returning word and keeps a sticky invalid flag.
  invalid is meaningful while done is high and clears one cycle later.
  ready follows done by one cycle.
*/
`timescale 1ns/1ns

module norm_check_top (
    input logic clk,
    input logic reset_n,
    input logic zeroize,
    input norm_check_pkg::chk_mode_t mode,
    coeff_rd_if.consumer rd,
    input logic last_beat,
    output logic invalid,
    output logic done,
    output logic ready
);
    import norm_check_pkg::*;

    logic [lanes-1:0] lane_invalid;
    logic any_invalid;
    logic flush_q;

    // One check unit per coefficient lane of the memory word
    for (genvar i = 0; i < lanes; i++) begin : gen_lane
        norm_check_unit i_norm_check_unit (
            .enable(rd.rd_data_valid),
            .mode(mode),
            .coeff(rd.rd_data[i*coeff_w +: coeff_w]),
            .invalid(lane_invalid[i])
        );
    end

    assign any_invalid = |lane_invalid;

    // A read already in flight at zeroize still returns a word next cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= zeroize;
        end
    end

    // Sticky OR of all lane flags, emptied once done has shown it
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            invalid <= 1'b0;
        end else if (zeroize || done) begin
            invalid <= 1'b0;
        end else if (!flush_q) begin
            invalid <= invalid | any_invalid;
        end
    end

    // done lands in the cycle after the final word
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            done <= 1'b0;
            ready <= 1'b0;
        end else if (zeroize) begin
            done <= 1'b0;
            ready <= 1'b0;
        end else begin
            done <= last_beat;
            // The extra cycle lets the caller capture invalid first
            ready <= done;
        end
    end

endmodule

/* norm_check/norm_check_subsys.sv */
/*
  Top level of the norm check: memory, read controller and check datapath.
  One enable checks one polynomial of 64 words starting at base_addr.
  Memory writes to words under an active read give unspecified results.
*/
`timescale 1ns/1ns

module norm_check_subsys (
    input logic clk,
    input logic reset_n,
    input logic zeroize,
    input logic wr_en,
    input norm_check_pkg::mem_addr_t wr_addr,
    input norm_check_pkg::mem_word_t wr_data,
    input logic enable,
    input norm_check_pkg::chk_mode_t mode,
    input norm_check_pkg::rand_t randomness,
    input norm_check_pkg::mem_addr_t base_addr,
    output logic invalid,
    output logic done,
    output logic ready
);

    logic last_beat;

    // Shared read path between the three blocks
    coeff_rd_if i_coeff_rd_if ();

    coeff_mem i_coeff_mem (
        .clk(clk),
        .reset_n(reset_n),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd(i_coeff_rd_if.responder)
    );

    norm_check_ctrl i_norm_check_ctrl (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize(zeroize),
        .enable(enable),
        .randomness(randomness),
        .base_addr(base_addr),
        .rd(i_coeff_rd_if.requester),
        .last_beat(last_beat)
    );

    norm_check_top i_norm_check_top (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize(zeroize),
        .mode(mode),
        .rd(i_coeff_rd_if.consumer),
        .last_beat(last_beat),
        .invalid(invalid),
        .done(done),
        .ready(ready)
    );

endmodule

/* verification/norm_check_props.sv */
/*
  Timing properties of the norm check output side, bound to norm_check_top.
  The read burst is watched through rd_data_valid, which repeats rd_en
  one cycle later, so both have the same run length.
*/
`timescale 1ns/1ns

module norm_check_props (
    input logic clk,
    input logic reset_n,
    input logic done,
    input logic ready,
    input logic rd_data_valid
);
    import norm_check_pkg::*;

    int valid_run;

    // Length of the current run of consecutive valid words
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_run <= 0;
        end else if (rd_data_valid) begin
            valid_run <= valid_run + 1;
        end else begin
            valid_run <= 0;
        end
    end

    // done is a single-cycle pulse
    done_single_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // ready comes exactly one cycle after done, and never on its own
    ready_after_done: assert property (@(posedge clk) disable iff (!reset_n)
        done |=> ready)
        else $error("ready did not follow done by one cycle");

    ready_needs_done: assert property (@(posedge clk) disable iff (!reset_n)
        ready |-> $past(done))
        else $error("ready rose without done in the cycle before");

    // One polynomial is at most 64 back-to-back reads
    read_burst_length: assert property (@(posedge clk) disable iff (!reset_n)
        valid_run <= words_per_poly)
        else $error("read burst ran longer than one polynomial");

endmodule

/* verification/norm_check_tb.sv */
/*
  Trace-driven testbench of the norm check subsystem. Memory is first filled
  with in-bound coefficients, then the trace writes words and runs checks.
  Expected invalid flags come from the trace, latencies from the fixed timing.
*/
`timescale 1ns/1ns

module norm_check_tb;
    import norm_check_pkg::*;

    localparam string trace_path = "verification/norm_check_trace.txt";
    localparam int done_latency = 66;
    localparam int ready_latency = 67;
    localparam int busy_enable_at = 10;
    localparam int zeroize_at = 20;
    localparam int quiet_cycles = 80;
    localparam int wait_limit = 200;

    logic clk;
    logic reset_n;
    logic zeroize;
    logic wr_en;
    mem_addr_t wr_addr;
    mem_word_t wr_data;
    logic enable;
    chk_mode_t mode;
    rand_t randomness;
    mem_addr_t base_addr;
    logic invalid;
    logic done;
    logic ready;

    // Trace operations, where op_addr is the write address or the check base
    byte op_kind [$];
    mem_addr_t op_addr [$];
    mem_word_t op_word [$];
    chk_mode_t op_mode [$];
    rand_t op_rand [$];
    logic op_exp [$];
    int op_act [$];

    int errors;
    int checks;
    int watchdog_cycles;
    integer seed;

    norm_check_subsys i_norm_check_subsys (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize(zeroize),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .enable(enable),
        .mode(mode),
        .randomness(randomness),
        .base_addr(base_addr),
        .invalid(invalid),
        .done(done),
        .ready(ready)
    );

    bind norm_check_top norm_check_props i_norm_check_props (
        .clk(clk),
        .reset_n(reset_n),
        .done(done),
        .ready(ready),
        .rd_data_valid(rd.rd_data_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_flag(input string name, input logic got, input logic exp,
                              input int op);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h (operation %0d)", name, got, exp, op);
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp, input int op);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %s cycle: got 0x%h, expected 0x%h (operation %0d)",
                     name, got, exp, op);
        end
    endtask

    // In-bound background, alternating signs, different for every address
    function automatic mem_word_t fill_word(input mem_addr_t addr);
        mem_word_t w;
        int unsigned mag;
        for (int j = 0; j < lanes; j++) begin
            mag = (int'(addr) * lanes + j + 1) * 211;
            if (j % 2 == 1) begin
                w[j*coeff_w +: coeff_w] = coeff_t'(mldsa_q) - coeff_t'(mag);
            end else begin
                w[j*coeff_w +: coeff_w] = coeff_t'(mag);
            end
        end
        return w;
    endfunction

    task automatic load_trace();
        int fd;
        int rc;
        string line;
        byte kind;
        logic [31:0] f_addr;
        logic [31:0] f_mode;
        logic [31:0] f_rand;
        logic [31:0] f_exp;
        logic [31:0] f_act;
        mem_word_t f_word;
        fd = $fopen(trace_path, "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the trace file %s", trace_path);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (rc > 0 && line.len() > 0) begin
                kind = line[0];
                if (kind == "W") begin
                    rc = $sscanf(line, "W %h %h", f_addr, f_word);
                    op_kind.push_back(kind);
                    op_addr.push_back(mem_addr_t'(f_addr));
                    op_word.push_back(f_word);
                    op_mode.push_back(mode_z);
                    op_rand.push_back('0);
                    op_exp.push_back(1'b0);
                    op_act.push_back(0);
                end else if (kind == "C") begin
                    rc = $sscanf(line, "C %h %h %h %h %h", f_mode, f_rand, f_addr, f_exp, f_act);
                    op_kind.push_back(kind);
                    op_addr.push_back(mem_addr_t'(f_addr));
                    op_word.push_back('0);
                    op_mode.push_back(chk_mode_t'(f_mode));
                    op_rand.push_back(rand_t'(f_rand));
                    op_exp.push_back(f_exp[0]);
                    op_act.push_back(int'(f_act));
                end else if (kind != "#" && kind != "\n" && kind != "\r" && kind != " ") begin
                    errors++;
                    $display("Unknown line in the trace file: %s", line);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic fill_memory();
        for (int a = 0; a < mem_depth; a++) begin
            @(posedge clk);
            wr_en <= 1'b1;
            wr_addr <= mem_addr_t'(a);
            wr_data <= fill_word(mem_addr_t'(a));
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic write_word(input mem_addr_t addr, input mem_word_t data);
        @(posedge clk);
        wr_en <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    // Returns at the edge that samples enable, which is cycle 0 of the run
    task automatic start_check(input chk_mode_t m, input rand_t r, input mem_addr_t b);
        @(posedge clk);
        mode <= m;
        randomness <= r;
        base_addr <= b;
        enable <= 1'b1;
        @(posedge clk);
        enable <= 1'b0;
    endtask

    task automatic run_check(input int op, input chk_mode_t m, input rand_t r,
                             input mem_addr_t b, input logic exp, input int act);
        int count;
        int done_cyc;
        int ready_cyc;
        logic flag_at_done;
        logic flag_after_done;
        count = 0;
        done_cyc = -1;
        ready_cyc = -1;
        flag_at_done = 1'b0;
        flag_after_done = 1'b0;
        start_check(m, r, b);
        // Outputs are sampled at the falling edge, between two driving edges
        while (ready_cyc < 0 && count < wait_limit) begin
            @(negedge clk);
            count++;
            if (done && done_cyc < 0) begin
                done_cyc = count;
                flag_at_done = invalid;
            end
            if (ready) begin
                ready_cyc = count;
                flag_after_done = invalid;
            end
            if (act == 1 && count == busy_enable_at) begin
                // A second enable with another base that must be dropped
                @(posedge clk);
                randomness <= ~r;
                base_addr <= b ^ 8'h40;
                enable <= 1'b1;
                @(posedge clk);
                enable <= 1'b0;
                count++;
            end
        end
        if (done_cyc < 0) begin
            errors++;
            $display("Operation %0d: done never arrived within %0d cycles", op, wait_limit);
        end else begin
            check_cycles("done", done_cyc, done_latency, op);
            check_flag("invalid", flag_at_done, exp, op);
        end
        if (ready_cyc < 0) begin
            errors++;
            $display("Operation %0d: ready never arrived within %0d cycles", op, wait_limit);
        end else begin
            check_cycles("ready", ready_cyc, ready_latency, op);
            check_flag("invalid after done", flag_after_done, 1'b0, op);
        end
        if (act == 1) begin
            repeat (quiet_cycles) begin
                @(negedge clk);
                if (done) begin
                    errors++;
                    $display("Operation %0d: an enable while busy started a second run", op);
                end
            end
        end
    endtask

    // Zeroize halfway through a run, then no done may follow
    task automatic abort_check(input int op, input chk_mode_t m, input rand_t r,
                               input mem_addr_t b);
        start_check(m, r, b);
        repeat (zeroize_at) @(negedge clk);
        @(posedge clk);
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        repeat (quiet_cycles) begin
            @(negedge clk);
            if (done || ready) begin
                errors++;
                $display("Operation %0d: done or ready appeared after zeroize", op);
            end
        end
        check_flag("invalid after zeroize", invalid, 1'b0, op);
    endtask

    initial begin
        int gap;
        reset_n = 1'b0;
        zeroize = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        enable = 1'b0;
        mode = mode_z;
        randomness = '0;
        base_addr = '0;
        errors = 0;
        checks = 0;
        seed = 12308;
        load_trace();
        watchdog_cycles = 100 * op_kind.size() + 1000;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        fill_memory();
        for (int i = 0; i < op_kind.size(); i++) begin
            gap = $random(seed) & 7;
            repeat (gap) @(posedge clk);
            if (op_kind[i] == "W") begin
                write_word(op_addr[i], op_word[i]);
            end else if (op_act[i] == 2) begin
                abort_check(i, op_mode[i], op_rand[i], op_addr[i]);
            end else begin
                run_check(i, op_mode[i], op_rand[i], op_addr[i], op_exp[i], op_act[i]);
            end
        end
        repeat (5) @(posedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Bound on the whole run, armed once the trace length is known
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles and the run did not finish",
                 watchdog_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* src.f */
common/norm_check_pkg.sv
common/coeff_rd_if.sv
logic/coeff_mem.sv
norm_check/norm_check_unit.sv
norm_check/norm_check_ctrl.sv
norm_check/norm_check_top.sv
norm_check/norm_check_subsys.sv
verification/norm_check_props.sv
verification/norm_check_tb.sv

/* Makefile */
# Verilator build and run of the norm check testbench
# Every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP ?= norm_check_tb
RTL_TOP ?= norm_check_subsys
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
JOBS ?= 4
VFLAGS ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The run passes only when the log holds the pass line
run: build
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/norm_check_trace.txt */
# W <addr> <word>: write one memory word, lane 0 in the low 24 bits, all fields hex
# C <mode> <rand> <base> <invalid> <action>: action 0 plain, 1 enable while busy, 2 zeroize
C 0 00 00 0 0
C 1 05 40 0 0
C 2 3f 80 0 0
C 3 11 c0 0 0
C 0 07 f0 0 0
W 40 00000000000000000007ff3b
C 0 00 40 0 0
W 40 00000000000000000007ff3c
C 0 00 40 1 0
C 0 2a 40 1 0
C 2 19 40 1 0
W 40 000000000000000000000000
W 5f 00000077e0c6000000000000
C 0 31 40 0 0
W 5f 00000077e0c5000000000000
C 0 00 40 1 0
C 0 3f 40 1 0
W 5f 000000000000000000000000
W 7f 03fe3b000000000000000000
C 1 00 40 0 0
W 7f 03fe3c000000000000000000
C 1 00 40 1 0
C 2 01 40 0 0
W 7f 000000000000000000000000
W 60 0000000000007be1c6000000
C 1 22 40 0 0
W 60 0000000000007be1c5000000
C 1 22 40 1 0
W 80 0000000000007be10203feff
C 2 00 80 0 0
W 9f 00000000000000000003ff00
C 2 00 80 1 0
W 9f 7be101000000000000000000
C 3 05 80 1 0
C 0 00 00 0 0
C 2 00 80 1 1
C 0 00 80 0 2
C 2 0c 80 1 0
